// File: verilog/mmu_pkg.sv
//--------------------
// Shared types and constants for the IIe MMU pipeline
// Holds queue and credit sizes, the region and target encodings
// and the records passed between pipeline stages
// Imported by every stage and by the testbench
//--------------------
package mmu_pkg;

    localparam int ADDR_W       = 16;
    localparam int QUEUE_DEPTH  = 4;     // Also the upstream credit count
    localparam int OUT_CREDITS  = 2;     // Mapper credits after reset
    localparam int QUEUE_PTR_W  = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W  = $clog2(QUEUE_DEPTH + 1);
    localparam int OUT_CREDIT_W = $clog2(OUT_CREDITS + 1);

    // Address regions found by the decoder
    typedef enum logic [3:0] {
        ram, kbd_switch, status, speaker, display_switch, lang_ctrl,
        slot_dev, slot_rom, exp_rom, sys_rom, other_io
    } region_e;

    // Where a mapped access ends up
    typedef enum logic [2:0] {
        main_ram, aux_ram, int_rom, slot_io, slot_rom_sel, switch_only, dropped
    } target_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
    } bus_access_t;

    typedef struct packed {
        bus_access_t bus;
        region_e     region;
    } decoded_access_t;

    // Switch snapshot seen by the mapper
    typedef struct packed {
        logic store80;
        logic ramrd;
        logic ramwrt;
        logic altzp;
        logic cxrom;
        logic c3rom;
        logic page2;
        logic hires;
        logic lc_bank1;
        logic lc_read;
        logic lc_write_en;
    } switch_state_t;

    typedef struct packed {
        decoded_access_t dec;
        switch_state_t   state;
        logic            status_bit;
    } switched_access_t;

    typedef struct packed {
        target_e           target;
        logic [ADDR_W-1:0] ram_addr;
        logic [2:0]        slot;
        logic              status_bit;
    } mapped_access_t;

endpackage

// File: verilog/access_queue.sv
//--------------------
// Input FIFO in front of the MMU pipeline
// Upstream sends only while holding a credit, one credit
// comes back on in_credit for every entry popped
//--------------------
`timescale 1ns/1ns

module access_queue import mmu_pkg::*;
(
    input  logic        CLK_14M,
    input  logic        reset,
    input  logic        in_valid,
    input  bus_access_t in_access,
    input  logic        stall,
    output logic        deq_valid,
    output bus_access_t deq_access,
    output logic        in_credit
);

    bus_access_t            mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   pop;

    assign pop = !stall && (count != '0);

    always_ff @(posedge CLK_14M)
    begin
        if (reset)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            deq_valid <= 1'b0;
            in_credit <= 1'b0;
        end
        else
        begin
            if (in_valid)
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (!stall)
                deq_valid <= pop;
            in_credit <= pop;             // One credit back per pop
        end
    end

    // Storage and head register
    always_ff @(posedge CLK_14M)
    begin
        if (in_valid)
            mem[wr_ptr] <= in_access;
        if (pop)
            deq_access <= mem[rd_ptr];
    end

endmodule

// File: verilog/bus_decoder.sv
//--------------------
// Stage 1 of the MMU pipeline
// Sorts each CPU address into an I/O or memory region and
// registers the access together with its region
//--------------------
`timescale 1ns/1ns

module bus_decoder import mmu_pkg::*;
(
    input  logic            CLK_14M,
    input  logic            reset,
    input  logic            deq_valid,
    input  bus_access_t     deq_access,
    input  logic            stall,
    output logic            dec_valid,
    output decoded_access_t dec_access
);

    logic [ADDR_W-1:0] addr;
    region_e           region;

    assign addr = deq_access.addr;

    // Nested decode of the C000-FFFF space
    always_comb
    begin
        region = other_io;
        if (addr[15:14] != 2'b11)
            region = ram;                             // 0000-BFFF
        else if (addr[13:12] != 2'b00)
            region = sys_rom;                         // D000-FFFF
        else
        begin
            case (addr[11:8])
                4'h0:
                begin
                    case (addr[7:4])
                        4'h0:    region = kbd_switch;     // C00x
                        4'h1:    region = status;         // C01x
                        4'h3:    region = speaker;        // C03x
                        4'h5:    region = display_switch; // C05x
                        4'h8:    region = lang_ctrl;      // C08x
                        4'h9, 4'hA, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF:
                            region = slot_dev;            // C09x-C0Fx
                        default: region = other_io;       // Tape, strobes, gameport
                    endcase
                end
                4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7:
                    region = slot_rom;                    // C100-C7FF
                default:
                    region = exp_rom;                     // C800-CFFF
            endcase
        end
    end

    always_ff @(posedge CLK_14M)
    begin
        if (reset)
            dec_valid <= 1'b0;
        else if (!stall)
            dec_valid <= deq_valid;
    end

    always_ff @(posedge CLK_14M)
    begin
        if (!stall)
        begin
            dec_access.bus    <= deq_access;
            dec_access.region <= region;
        end
    end

endmodule

// File: verilog/switch_bank.sv
//--------------------
// Stage 2 of the MMU pipeline
// Holds the IIe soft switches and applies their side effects
// in arrival order, then passes on a switch snapshot and the
// C01x status bit with each access
//--------------------
`timescale 1ns/1ns

module switch_bank import mmu_pkg::*;
(
    input  logic             CLK_14M,
    input  logic             reset,
    input  logic             dec_valid,
    input  decoded_access_t  dec_access,
    input  logic             stall,
    output logic             sw_valid,
    output switched_access_t sw_access,
    output logic             speaker,
    output logic [3:0]       annunciators
);

    logic [ADDR_W-1:0] addr;
    logic              write;
    logic              take;
    logic [7:0]        aux_sw;       // C00x write switches
    logic [7:0]        disp_sw;      // C05x, upper nibble is AN0-AN3
    logic              lc_bank1;
    logic              lc_read;
    logic              lc_write_en;
    logic              lc_pre_wr;    // First odd read seen
    logic              spk;
    switch_state_t     state;
    logic              status_bit;

    assign addr  = dec_access.bus.addr;
    assign write = dec_access.bus.write;
    assign take  = dec_valid && !stall;

    assign speaker      = spk;
    assign annunciators = disp_sw[7:4];

    // Snapshot before this access takes effect
    always_comb
    begin
        state.store80     = aux_sw[0];
        state.ramrd       = aux_sw[1];
        state.ramwrt      = aux_sw[2];
        state.cxrom       = aux_sw[3];
        state.altzp       = aux_sw[4];
        state.c3rom       = aux_sw[5];
        state.page2       = disp_sw[2];
        state.hires       = disp_sw[3];
        state.lc_bank1    = lc_bank1;
        state.lc_read     = lc_read;
        state.lc_write_en = lc_write_en;
    end

    //--------------------
    // C01x status reads
    //--------------------
    always_comb
    begin
        status_bit = 1'b0;
        if (dec_access.region == status && !write)
        begin
            case (addr[3:0])
                4'h1:    status_bit = ~lc_bank1;   // Bank 2 active
                4'h2:    status_bit = lc_read;
                4'h3:    status_bit = aux_sw[1];
                4'h4:    status_bit = aux_sw[2];
                4'h5:    status_bit = aux_sw[3];
                4'h6:    status_bit = aux_sw[4];
                4'h7:    status_bit = aux_sw[5];
                4'h8:    status_bit = aux_sw[0];
                4'hA:    status_bit = disp_sw[0];  // Text
                4'hB:    status_bit = disp_sw[1];  // Mixed
                4'hC:    status_bit = disp_sw[2];
                4'hD:    status_bit = disp_sw[3];
                4'hE:    status_bit = aux_sw[7];   // Altchar
                4'hF:    status_bit = aux_sw[6];   // 80 column
                default: status_bit = 1'b0;        // Key strobe and VBL
            endcase
        end
    end

    //--------------------
    // Side effects
    //--------------------
    always_ff @(posedge CLK_14M)
    begin
        if (reset)
        begin
            sw_valid    <= 1'b0;
            aux_sw      <= '0;
            disp_sw     <= '0;
            lc_bank1    <= 1'b0;
            lc_read     <= 1'b0;
            lc_write_en <= 1'b0;
            lc_pre_wr   <= 1'b0;
            spk         <= 1'b0;
        end
        else
        begin
            if (!stall)
                sw_valid <= dec_valid;
            if (take)
            begin
                case (dec_access.region)
                    kbd_switch:
                        if (write)
                            aux_sw[addr[3:1]] <= addr[0];
                    display_switch:
                        disp_sw[addr[3:1]] <= addr[0];
                    mmu_pkg::speaker:
                        spk <= ~spk;
                    lang_ctrl:
                    begin
                        lc_bank1  <= addr[3];
                        lc_read   <= ~(addr[0] ^ addr[1]);
                        lc_pre_wr <= addr[0] & ~write;
                        if (lc_pre_wr && !write && addr[0])
                            lc_write_en <= 1'b1;  // Second odd read
                        else if (!addr[0])
                            lc_write_en <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge CLK_14M)
    begin
        if (!stall)
        begin
            sw_access.dec        <= dec_access;
            sw_access.state      <= state;
            sw_access.status_bit <= status_bit;
        end
    end

endmodule

// File: verilog/memory_mapper.sv
//--------------------
// Stage 3 of the MMU pipeline
// Picks the target and RAM address of each access, sends it
// under output credits and holds one item when none is left,
// raising stall for the stages in front
//--------------------
`timescale 1ns/1ns

module memory_mapper import mmu_pkg::*;
(
    input  logic             CLK_14M,
    input  logic             reset,
    input  logic             sw_valid,
    input  switched_access_t sw_access,
    input  logic             out_credit,
    output logic             stall,
    output logic             out_valid,
    output mapped_access_t   out_access
);

    logic [OUT_CREDIT_W-1:0] credits;
    logic                    credit_ok;
    logic                    send;
    logic                    held_valid;
    mapped_access_t          held;
    mapped_access_t          mapped;
    logic [ADDR_W-1:0]       addr;
    logic [ADDR_W-1:0]       lc_addr;
    switch_state_t           st;
    logic                    rw_aux;
    logic                    use_aux;
    target_e                 ram_tgt;

    assign addr      = sw_access.dec.bus.addr;
    assign st        = sw_access.state;
    assign credit_ok = (credits != '0);
    assign stall     = held_valid && !credit_ok;
    assign send      = credit_ok && (held_valid || sw_valid);

    // Main/aux select
    always_comb
    begin
        rw_aux = sw_access.dec.bus.write ? st.ramwrt : st.ramrd;
        if (addr[15:9] == 7'h00 || addr[15:14] == 2'b11)
            use_aux = st.altzp;                              // Pages 00-01, C0-FF
        else if (addr[15:10] == 6'b000001)
            use_aux = st.store80 ? st.page2 : rw_aux;        // Text pages
        else if (addr[15:13] == 3'b001)
            use_aux = (st.store80 && st.hires) ? st.page2 : rw_aux;
        else
            use_aux = rw_aux;
        ram_tgt = use_aux ? aux_ram : main_ram;
        lc_addr = {addr[15:13], addr[12] & ~(st.lc_bank1 && addr[15:12] == 4'hD),
                   addr[11:0]};
    end

    //--------------------
    // Target decode
    //--------------------
    always_comb
    begin
        mapped.target     = switch_only;
        mapped.ram_addr   = addr;
        mapped.slot       = 3'd0;
        mapped.status_bit = sw_access.status_bit;
        case (sw_access.dec.region)
            ram:
                mapped.target = ram_tgt;
            sys_rom:
            begin
                if (sw_access.dec.bus.write ? st.lc_write_en : st.lc_read)
                begin
                    mapped.target   = ram_tgt;
                    mapped.ram_addr = lc_addr;
                end
                else
                    mapped.target = sw_access.dec.bus.write ? dropped : int_rom;
            end
            slot_rom:
            begin
                mapped.slot = addr[10:8];
                if (st.cxrom || (addr[10:8] == 3'd3 && !st.c3rom))
                    mapped.target = int_rom;
                else
                    mapped.target = slot_rom_sel;
            end
            exp_rom:
                mapped.target = st.cxrom ? int_rom : slot_rom_sel;  // Strobe otherwise
            slot_dev:
            begin
                mapped.target = slot_io;
                mapped.slot   = addr[6:4];
            end
            other_io:
                mapped.target = dropped;
            default:
                mapped.target = switch_only;
        endcase
    end

    always_ff @(posedge CLK_14M)
    begin
        if (reset)
        begin
            credits    <= OUT_CREDIT_W'(OUT_CREDITS);
            held_valid <= 1'b0;
            out_valid  <= 1'b0;
        end
        else
        begin
            out_valid <= send;
            case ({send, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
            if (held_valid)
            begin
                if (credit_ok)
                    held_valid <= sw_valid;   // Refill behind the sent item
            end
            else if (sw_valid && !credit_ok)
                held_valid <= 1'b1;
        end
    end

    // Payload, held item goes out first
    always_ff @(posedge CLK_14M)
    begin
        if (send)
            out_access <= held_valid ? held : mapped;
        if ((held_valid && credit_ok) || (!held_valid && !credit_ok))
            held <= mapped;
    end

endmodule

// File: verilog/apple2e_mmu.sv
//--------------------
// Top of the IIe MMU pipeline
// Queue, decoder, switch bank and mapper in a chain, with
// credit flow control on both the input and output side
//--------------------
`timescale 1ns/1ns

module apple2e_mmu import mmu_pkg::*;
(
    input  logic           CLK_14M,
    input  logic           reset,
    input  logic           in_valid,
    input  bus_access_t    in_access,
    output logic           in_credit,
    output logic           out_valid,
    output mapped_access_t out_access,
    input  logic           out_credit,
    output logic           speaker,
    output logic [3:0]     annunciators
);

    logic             deq_valid;
    bus_access_t      deq_access;
    logic             dec_valid;
    decoded_access_t  dec_access;
    logic             sw_valid;
    switched_access_t sw_access;
    logic             stall;          // From the mapper to every stage

    access_queue u_queue (
        .CLK_14M    (CLK_14M),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_access  (in_access),
        .stall      (stall),
        .deq_valid  (deq_valid),
        .deq_access (deq_access),
        .in_credit  (in_credit)
    );

    bus_decoder u_decoder (
        .CLK_14M    (CLK_14M),
        .reset      (reset),
        .deq_valid  (deq_valid),
        .deq_access (deq_access),
        .stall      (stall),
        .dec_valid  (dec_valid),
        .dec_access (dec_access)
    );

    switch_bank u_switches (
        .CLK_14M      (CLK_14M),
        .reset        (reset),
        .dec_valid    (dec_valid),
        .dec_access   (dec_access),
        .stall        (stall),
        .sw_valid     (sw_valid),
        .sw_access    (sw_access),
        .speaker      (speaker),
        .annunciators (annunciators)
    );

    memory_mapper u_mapper (
        .CLK_14M    (CLK_14M),
        .reset      (reset),
        .sw_valid   (sw_valid),
        .sw_access  (sw_access),
        .out_credit (out_credit),
        .stall      (stall),
        .out_valid  (out_valid),
        .out_access (out_access)
    );

endmodule

// File: sim/mmu_properties.sv
//--------------------
// Concurrent checks on the mapper credit logic
// Bound to memory_mapper from the testbench file list
//--------------------
`timescale 1ns/1ns

module mmu_properties import mmu_pkg::*;
(
    input logic                    CLK_14M,
    input logic                    reset,
    input logic                    out_valid,
    input logic                    out_credit,
    input logic                    stall,
    input logic [OUT_CREDIT_W-1:0] credits
);

    int granted;              // Credits held by the mapper, counted at its ports
    int assert_fails = 0;     // Failed assertions so far

    always @(posedge CLK_14M)
    begin
        if (reset)
            granted <= OUT_CREDITS;
        else
            granted <= granted - int'(out_valid) + int'(out_credit);
    end

    // Every out_valid pulse spends a credit the port count still holds
    valid_needs_credit: assert property (@(posedge CLK_14M) disable iff (reset)
        out_valid |-> granted > 0)
        else
        begin
            $error("out_valid fired without an output credit");
            assert_fails++;
        end

    credits_in_range: assert property (@(posedge CLK_14M) disable iff (reset)
        credits <= OUT_CREDIT_W'(OUT_CREDITS))
        else
        begin
            $error("output credit count above its reset value");
            assert_fails++;
        end

    quiet_after_reset: assert property (@(posedge CLK_14M)
        reset |=> (!out_valid && !stall))
        else
        begin
            $error("out_valid or stall high right after reset");
            assert_fails++;
        end

endmodule

bind memory_mapper mmu_properties props_i (
    .CLK_14M    (CLK_14M),
    .reset      (reset),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .stall      (stall),
    .credits    (credits)
);

// File: sim/mmu_checker.sv
//--------------------
// Output checker for the MMU testbench
// Loads the expected accesses from the data file, compares every
// out_valid in order and checks speaker and annunciators at the end
//--------------------
`timescale 1ns/1ns

module mmu_checker import mmu_pkg::*;
(
    input  logic           CLK_14M,
    input  logic           reset,
    input  logic           out_valid,
    input  mapped_access_t out_access,
    input  logic           speaker,
    input  logic [3:0]     annunciators,
    input  logic           drain,
    output int             checked,
    output int             errors,
    output logic           final_done
);

    mapped_access_t expected [64];
    int             n_exp;
    logic           exp_speaker;
    logic [3:0]     exp_ann;

    task automatic load_expected();
        int    fd;
        int    rc;
        int    kind;
        int    a;
        int    w;
        int    t;
        int    r;
        int    s;
        int    b;
        string line;
        n_exp = 0;
        fd = $fopen("sim/stimulus_input.txt", "r");
        if (fd == 0)
        begin
            $display("Checker could not open the stimulus file");
            errors = errors + 1;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                rc = $fgets(line, fd);
                if (line.len() < 2 || line.substr(0, 0) == "#")
                    continue;
                rc = $sscanf(line, "%h %h %h %h %h %h %h", kind, a, w, t, r, s, b);
                if (kind == 1 && rc == 7)
                begin
                    expected[n_exp].target     = target_e'(t[2:0]);
                    expected[n_exp].ram_addr   = r[15:0];
                    expected[n_exp].slot       = s[2:0];
                    expected[n_exp].status_bit = b[0];
                    n_exp = n_exp + 1;
                end
                else if (kind == 2)
                begin
                    exp_speaker = a[0];       // Final line, speaker then annunciators
                    exp_ann     = w[3:0];
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic int compare_field(string name, int exp_v, int got_v);
        if (exp_v != got_v)
        begin
            $display("Mismatch at %0t ns: %s expected 0x%0h got 0x%0h",
                     $time, name, exp_v, got_v);
            return 1;
        end
        return 0;
    endfunction

    initial
    begin
        checked    = 0;
        errors     = 0;
        final_done = 1'b0;
        load_expected();
    end

    always @(posedge CLK_14M)
    begin
        int bad;
        bad = 0;
        if (!reset && out_valid)
        begin
            if (checked >= n_exp)
            begin
                $display("Extra out_valid at %0t ns with no access left to expect", $time);
                errors = errors + 1;
            end
            else
            begin
                bad += compare_field("out_access.target", expected[checked].target,
                                     out_access.target);
                bad += compare_field("out_access.ram_addr", expected[checked].ram_addr,
                                     out_access.ram_addr);
                bad += compare_field("out_access.slot", expected[checked].slot,
                                     out_access.slot);
                bad += compare_field("out_access.status_bit", expected[checked].status_bit,
                                     out_access.status_bit);
                $display("access %0d: %s", checked, (bad == 0) ? "ok" : "FAILED");
                errors = errors + bad;
            end
            checked = checked + 1;
        end
        if (drain && !final_done)
        begin
            bad = 0;
            bad += compare_field("speaker", exp_speaker, speaker);
            bad += compare_field("annunciators", exp_ann, annunciators);
            $display("final port state: %s", (bad == 0) ? "ok" : "FAILED");
            errors     = errors + bad;
            final_done = 1'b1;
        end
    end

endmodule

// File: sim/tb_top.sv
//--------------------
// Testbench top for the IIe MMU pipeline
// Feeds accesses from the data file under input credits, returns
// output credits on LFSR choice and prints the summary
//--------------------
`timescale 1ns/1ns

module tb_top import mmu_pkg::*;
();

    localparam int MAX_ACC = 64;
    localparam int TIMEOUT = 5000;   // Cycles per wait

    logic           CLK_14M;
    logic           reset;
    logic           in_valid;
    bus_access_t    in_access;
    logic           in_credit;
    logic           out_valid;
    mapped_access_t out_access;
    logic           out_credit;
    logic           speaker;
    logic [3:0]     annunciators;

    bus_access_t    stim [MAX_ACC];
    int             n_acc;
    int             sent;
    int             in_credits;
    int             owed;            // Output credits taken, not yet returned
    logic [7:0]     lfsr;
    logic           give;
    logic           running;
    logic           drain;
    int             tb_errors;
    int             checked;
    int             errors;
    logic           final_done;

    always #4 CLK_14M = ~CLK_14M;

    apple2e_mmu dut_i (
        .CLK_14M      (CLK_14M),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_access    (in_access),
        .in_credit    (in_credit),
        .out_valid    (out_valid),
        .out_access   (out_access),
        .out_credit   (out_credit),
        .speaker      (speaker),
        .annunciators (annunciators)
    );

    mmu_checker checker_i (
        .CLK_14M      (CLK_14M),
        .reset        (reset),
        .out_valid    (out_valid),
        .out_access   (out_access),
        .speaker      (speaker),
        .annunciators (annunciators),
        .drain        (drain),
        .checked      (checked),
        .errors       (errors),
        .final_done   (final_done)
    );

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    rc;
        int    kind;
        int    a;
        int    w;
        string line;
        fd = $fopen("sim/stimulus_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file");
            tb_errors = tb_errors + 1;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            rc = $sscanf(line, "%h %h %h", kind, a, w);
            if (kind == 1 && n_acc < MAX_ACC)
            begin
                stim[n_acc] = '{addr: a[15:0], write: w[0]};
                n_acc = n_acc + 1;
            end
        end
        $fclose(fd);
    endtask

    function automatic logic cond_met(input int which);
        case (which)
            0:       return sent == n_acc;
            1:       return checked >= n_acc;
            default: return final_done;
        endcase
    endfunction

    task automatic wait_until(input int which, input string what);
        int cycles;
        cycles = 0;
        while (!cond_met(which) && cycles < TIMEOUT)
        begin
            @(posedge CLK_14M);
            cycles = cycles + 1;
        end
        if (!cond_met(which))
        begin
            $display("Timeout while waiting for %s", what);
            tb_errors = tb_errors + 1;
        end
    endtask

    //--------------------
    // Input side
    //--------------------
    always @(posedge CLK_14M)
    begin
        if (reset)
        begin
            in_valid   <= 1'b0;
            in_credits <= QUEUE_DEPTH;
            sent       <= 0;
        end
        else if (running && sent < n_acc && in_credits > 0)
        begin
            in_valid   <= 1'b1;
            in_access  <= stim[sent];
            sent       <= sent + 1;
            in_credits <= in_credits - 1 + int'(in_credit);
        end
        else
        begin
            in_valid   <= 1'b0;
            in_credits <= in_credits + int'(in_credit);
        end
    end

    // Output credits come back at random
    always @(posedge CLK_14M)
    begin
        if (reset)
        begin
            out_credit <= 1'b0;
            owed       <= 0;
            lfsr       <= 8'd67;
        end
        else
        begin
            give = (owed > 0) && (drain || lfsr[0]);
            if (owed > 0 && !drain)
                lfsr <= lfsr_next(lfsr);   // One step per bit used
            out_credit <= give;
            owed       <= owed + int'(out_valid) - int'(give);
        end
    end

    initial
    begin
        int fails;
        CLK_14M   = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_access = '0;
        out_credit = 1'b0;
        running   = 1'b0;
        drain     = 1'b0;
        tb_errors = 0;
        n_acc     = 0;
        load_stimulus();
        repeat (10) @(posedge CLK_14M);
        reset   <= 1'b0;
        running <= 1'b1;
        wait_until(0, "all accesses to be sent");
        if (tb_errors == 0)
            wait_until(1, "all accesses to come out");
        if (tb_errors == 0)
        begin
            repeat (20) @(posedge CLK_14M);  // Catch any stray out_valid
            drain <= 1'b1;
            wait_until(2, "the final port check");
        end
        if (checked != n_acc)
        begin
            $display("Saw %0d out_valid pulses for %0d accesses", checked, n_acc);
            tb_errors = tb_errors + 1;
        end
        fails = errors + tb_errors + dut_i.u_mapper.props_i.assert_fails;
        $display("Summary: %0d accesses, %0d outputs, %0d errors",
                 n_acc, checked, fails);
        if (fails == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: sim/stimulus_input.txt
# kind(1=access) addr write | expected target ram_addr slot status_bit
# kind 2 is the final line: expected speaker, annunciators
1 0300 0 0 0300 0 0
1 0300 1 0 0300 0 0
1 C600 0 4 C600 6 0
1 C300 0 2 C300 3 0
1 C0E5 0 3 C0E5 6 0
1 C800 0 4 C800 0 0
1 E000 0 2 E000 0 0
1 E000 1 6 E000 0 0
1 C020 0 6 C020 0 0
1 C003 1 5 C003 0 0
1 C005 1 5 C005 0 0
1 2000 0 1 2000 0 0
1 2000 1 1 2000 0 0
1 C013 0 5 C013 0 1
1 C014 0 5 C014 0 1
1 C009 1 5 C009 0 0
1 0100 0 1 0100 0 0
1 C016 0 5 C016 0 1
1 C002 1 5 C002 0 0
1 C004 1 5 C004 0 0
1 C001 1 5 C001 0 0
1 C055 0 5 C055 0 0
1 C057 0 5 C057 0 0
1 C018 0 5 C018 0 1
1 0400 0 1 0400 0 0
1 2000 0 1 2000 0 0
1 6000 0 0 6000 0 0
1 C008 1 5 C008 0 0
1 C08B 0 5 C08B 0 0
1 C08B 0 5 C08B 0 0
1 D123 0 0 C123 0 0
1 D123 1 0 C123 0 0
1 C012 0 5 C012 0 1
1 C011 0 5 C011 0 0
1 C080 0 5 C080 0 0
1 D123 1 6 D123 0 0
1 D123 0 0 D123 0 0
1 C030 0 5 C030 0 0
1 C030 0 5 C030 0 0
1 C030 1 5 C030 0 0
1 C059 0 5 C059 0 0
1 C05F 0 5 C05F 0 0
2 1 9

// File: tb.f
verilog/mmu_pkg.sv
verilog/access_queue.sv
verilog/bus_decoder.sv
verilog/switch_bank.sv
verilog/memory_mapper.sv
verilog/apple2e_mmu.sv
sim/mmu_properties.sv
sim/mmu_checker.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
